// File: hw/conv0_pkg.sv
// conv0 shared layer constants, beat structs and quantizer thresholds
package conv0_pkg;

	localparam int NUM_CH    = 3;		// input channels per beat
	localparam int NUM_LANES = 3;		// output pixels per beat
	localparam int NUM_TAPS  = 9;		// 3x3 kernel, one pass per tap
	localparam int ROW_BEATS = 16;		// beats per row, also psum FIFO depth

	localparam int ACT_W  = 8;			// unsigned activation
	localparam int WGT_W  = 8;			// signed weight
	localparam int PSUM_W = 24;			// signed partial sum

	localparam int TAP_W  = 4;			// tap index width
	localparam int CH_W   = 2;			// channel index width
	localparam int BEAT_W = $clog2(ROW_BEATS);

	localparam int QSHIFT = 7;			// products drift the point, scale down by 128

	// 2-bit quantizer steps at 1/6, 1/2 and 5/6 of 128
	localparam int Q_REF0 = 21;
	localparam int Q_REF1 = 64;
	localparam int Q_REF2 = 107;

	typedef struct packed {
		logic [NUM_LANES-1:0][NUM_CH-1:0][ACT_W-1:0] px;	// [lane][ch]
	} act_beat_t;

	typedef struct packed {
		act_beat_t        beat;
		logic [TAP_W-1:0] tap;			// equals the pass number
		logic             is_first;
		logic             is_last;
	} tap_beat_t;

	typedef struct packed {
		logic [TAP_W-1:0]        tap;
		logic [CH_W-1:0]         ch;
		logic signed [WGT_W-1:0] value;
	} wgt_wr_t;

	// partial sums are two's complement, read them through $signed
	typedef struct packed {
		logic [NUM_LANES-1:0][PSUM_W-1:0] psum;
	} psum_row_t;

	typedef struct packed {
		psum_row_t row;
		logic      is_first;
		logic      is_last;
	} mac_beat_t;

	typedef struct packed {
		logic [NUM_LANES-1:0][1:0] q;	// one 2-bit value per lane
	} ofm_beat_t;

endpackage

// File: hw/psum_fifo.sv
// psum FIFO, first-word fall-through circular buffer holding a row of partial sums
`timescale 1ns/1ps

module psum_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;

	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];		// head is visible before the pop

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;			// idle, or push and pop together
			endcase
		end
	end

	// a full FIFO may still take a push in the same cycle as a pop
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(push && full && !pop)
	) else $error("psum_fifo: push while full");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(pop && empty)
	) else $error("psum_fifo: pop while empty");

endmodule

// File: hw/conv0_seq.sv
// conv0 sequencer, accepts input beats and tags them with tap index and pass flags
`timescale 1ns/1ps

module conv0_seq import conv0_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      advance,
	input  logic      in_valid,
	input  act_beat_t in_data,
	output logic      s1_valid,
	output tap_beat_t s1_data
);

	logic [BEAT_W-1:0] beat_cnt;
	logic [TAP_W-1:0]  pass_cnt;
	logic              accept;
	logic              row_end;
	logic              frame_end;

	assign accept    = in_valid && advance;
	assign row_end   = (beat_cnt == BEAT_W'(ROW_BEATS - 1));
	assign frame_end = (pass_cnt == TAP_W'(NUM_TAPS - 1));

	// beat and pass counters, both wrap at the end of a frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
			pass_cnt <= '0;
		end else if (accept) begin
			if (row_end) begin
				beat_cnt <= '0;
				pass_cnt <= frame_end ? '0 : pass_cnt + 1'b1;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
		end
	end

	// stage 1 payload
	always_ff @(posedge clk) begin
		if (accept) begin
			s1_data <= '{
				beat:     in_data,
				tap:      pass_cnt,
				is_first: (pass_cnt == '0),
				is_last:  frame_end
			};
		end
	end

	a_pass_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		pass_cnt <= TAP_W'(NUM_TAPS - 1)
	) else $error("conv0_seq: pass count out of range");

endmodule

// File: hw/conv0_mac.sv
// conv0 MAC stage, per-tap weight table and per-lane multiply with channel sum
`timescale 1ns/1ps

module conv0_mac import conv0_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      advance,
	input  logic      wgt_we,
	input  wgt_wr_t   wgt_wr,
	input  logic      s1_valid,
	input  tap_beat_t s1_data,
	output logic      s2_valid,
	output mac_beat_t s2_data
);

	logic signed [WGT_W-1:0]  wgt [NUM_TAPS][NUM_CH];
	logic signed [PSUM_W-1:0] lane_sum [NUM_LANES];

	// weight table, written only while the pipeline is idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < NUM_TAPS; t++) begin
				for (int c = 0; c < NUM_CH; c++) begin
					wgt[t][c] <= '0;
				end
			end
		end else if (wgt_we) begin
			wgt[wgt_wr.tap][wgt_wr.ch] <= wgt_wr.value;
		end
	end

	// activations are unsigned, so widen with a zero before the signed multiply
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_sum[l] = '0;
			for (int c = 0; c < NUM_CH; c++) begin
				lane_sum[l] = lane_sum[l]
					+ $signed({1'b0, s1_data.beat.px[l][c]}) * wgt[s1_data.tap][c];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else if (advance) begin
			s2_valid <= s1_valid;
		end
	end

	// stage 2 payload, flags follow the sums
	always_ff @(posedge clk) begin
		if (advance && s1_valid) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				s2_data.row.psum[l] <= lane_sum[l];
			end
			s2_data.is_first <= s1_data.is_first;
			s2_data.is_last  <= s1_data.is_last;
		end
	end

	// a write mid-frame would mix two weight sets into one output row
	a_wgt_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(wgt_we && (s1_valid || s2_valid))
	) else $error("conv0_mac: weight write while beats are in flight");

endmodule

// File: hw/conv0_go.sv
// conv0 output feature map generator that accumulates passes and quantizes the last to 2 bits
`timescale 1ns/1ps

module conv0_go import conv0_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      advance,
	input  logic      s2_valid,
	input  mac_beat_t s2_data,
	output logic      out_valid,
	output ofm_beat_t out_data
);

	psum_row_t fifo_head;
	psum_row_t prev_row;
	psum_row_t sum_row;
	ofm_beat_t ofm_next;
	logic      fifo_push;
	logic      fifo_pop;
	logic      fifo_full;
	logic      fifo_empty;

	// q = T >>> QSHIFT and negative totals clamp to level 0
	function automatic logic [1:0] quantize(input logic [PSUM_W-1:0] total);
		logic signed [PSUM_W-1:0] q;
		q = $signed(total) >>> QSHIFT;
		if (total[PSUM_W-1] || q < Q_REF0) begin
			return 2'd0;
		end else if (q < Q_REF1) begin
			return 2'd1;
		end else if (q < Q_REF2) begin
			return 2'd2;
		end else begin
			return 2'd3;
		end
	endfunction

	assign fifo_push = advance && s2_valid && !s2_data.is_last;
	assign fifo_pop  = advance && s2_valid && !s2_data.is_first;
	assign prev_row  = s2_data.is_first ? '0 : fifo_head;		// first pass starts from zero

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			sum_row.psum[l] = s2_data.row.psum[l] + prev_row.psum[l];
			ofm_next.q[l]   = quantize(sum_row.psum[l]);
		end
	end

	psum_fifo #(
		.payload_t (psum_row_t),
		.DEPTH     (ROW_BEATS)
	) u_psum_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (fifo_push),
		.push_data (sum_row),
		.pop       (fifo_pop),
		.pop_data  (fifo_head),
		.full      (fifo_full),
		.empty     (fifo_empty)
	);

	// advance is high whenever the held output is free or being taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= s2_valid && s2_data.is_last;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && s2_valid && s2_data.is_last) begin
			out_data <= ofm_next;
		end
	end

	// the first pass of a frame must find no row left over from the last frame
	a_first_pass_clean: assert property (
		@(posedge clk) disable iff (!rst_n)
		s2_valid && s2_data.is_first |-> !fifo_full
	) else $error("conv0_go: stale partial sums at frame start");

	// the last pass must always find the previous pass's row waiting
	a_last_pass_fed: assert property (
		@(posedge clk) disable iff (!rst_n)
		s2_valid && s2_data.is_last && !s2_data.is_first |-> !fifo_empty
	) else $error("conv0_go: last pass without partial sums");

endmodule

// File: hw/conv0_top.sv
// conv0 layer top, sequencer, MAC and output generator under one stall enable
`timescale 1ns/1ps

module conv0_top import conv0_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  act_beat_t in_data,
	input  logic      wgt_we,
	input  wgt_wr_t   wgt_wr,
	output logic      out_valid,
	input  logic      out_ready,
	output ofm_beat_t out_data
);

	logic      advance;
	logic      s1_valid;
	tap_beat_t s1_data;
	logic      s2_valid;
	mac_beat_t s2_data;

	// whole pipeline freezes only while a held result is refused
	assign advance  = !(out_valid && !out_ready);
	assign in_ready = advance;

	conv0_seq u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.advance  (advance),
		.in_valid (in_valid),
		.in_data  (in_data),
		.s1_valid (s1_valid),
		.s1_data  (s1_data)
	);

	conv0_mac u_mac (
		.clk      (clk),
		.rst_n    (rst_n),
		.advance  (advance),
		.wgt_we   (wgt_we),
		.wgt_wr   (wgt_wr),
		.s1_valid (s1_valid),
		.s1_data  (s1_data),
		.s2_valid (s2_valid),
		.s2_data  (s2_data)
	);

	conv0_go u_go (
		.clk       (clk),
		.rst_n     (rst_n),
		.advance   (advance),
		.s2_valid  (s2_valid),
		.s2_data   (s2_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: tb/conv0_tb.sv
// conv0 testbench running directed tests of the layer against a reference model
`timescale 1ns/1ps

module conv0_tb import conv0_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;		// cycles before a wait gives up

	logic      clk = 1'b0;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	act_beat_t in_data;
	logic      wgt_we;
	wgt_wr_t   wgt_wr;
	logic      out_valid;
	logic      out_ready = 1'b1;
	ofm_beat_t out_data;

	int        wgt_m [NUM_TAPS][NUM_CH];		// weights as loaded into the DUT
	act_beat_t frame_act [NUM_TAPS][ROW_BEATS];	// [tap][beat]
	act_beat_t stim_q [$];
	ofm_beat_t exp_q [$];
	ofm_beat_t mon_exp;
	string     cur_test = "none";
	bit        bp_mode = 1'b0;
	bit        aborted = 1'b0;		// set once a wait has timed out
	int        out_count = 0;
	int        compared = 0;
	int        mismatches = 0;
	int        strays = 0;
	int        value_errs = 0;
	int        other_errs = 0;

	conv0_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.wgt_we    (wgt_we),
		.wgt_wr    (wgt_wr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		out_ready <= bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;	// random sink stalls
	end

	// output monitor comparing every transfer with the head of the expected queue
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			out_count++;
			if (exp_q.size() == 0) begin
				$display("%s: an output appeared when none was expected", cur_test);
				strays++;
			end else begin
				mon_exp = exp_q.pop_front();
				compared++;
				if (out_data !== mon_exp) begin
					$display("[FAIL] %s: expected %b, actual %b", cur_test, mon_exp, out_data);
					mismatches++;
				end
			end
		end
	end

	// level from thresholds scaled back up by 128 where negatives fall below the first
	function automatic logic [1:0] ref_level(input int total);
		if (total < (Q_REF0 << QSHIFT)) return 2'd0;
		if (total < (Q_REF1 << QSHIFT)) return 2'd1;
		if (total < (Q_REF2 << QSHIFT)) return 2'd2;
		return 2'd3;
	endfunction

	function automatic int ref_total(input int b, input int l);
		int s;
		s = 0;
		for (int t = 0; t < NUM_TAPS; t++) begin
			for (int c = 0; c < NUM_CH; c++) begin
				s += int'(frame_act[t][b].px[l][c]) * wgt_m[t][c];
			end
		end
		return s;
	endfunction

	task automatic finish_run();
		$display("outputs %0d, mismatches %0d, strays %0d, value errors %0d, other errors %0d",
			compared, mismatches, strays, value_errs, other_errs);
		if (mismatches + strays + value_errs + other_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	task automatic fill_acts(input bit rnd);
		for (int t = 0; t < NUM_TAPS; t++)
			for (int b = 0; b < ROW_BEATS; b++)
				for (int l = 0; l < NUM_LANES; l++)
					for (int c = 0; c < NUM_CH; c++)
						frame_act[t][b].px[l][c] = rnd ? 8'($urandom)
							: 8'(t * 37 + b * 11 + l * 5 + c * 3);
	endtask

	// one frame is the row sent once per tap and its expected row follows the current weights
	task automatic queue_frame();
		ofm_beat_t e;
		for (int t = 0; t < NUM_TAPS; t++)
			for (int b = 0; b < ROW_BEATS; b++)
				stim_q.push_back(frame_act[t][b]);
		for (int b = 0; b < ROW_BEATS; b++) begin
			for (int l = 0; l < NUM_LANES; l++) e.q[l] = ref_level(ref_total(b, l));
			exp_q.push_back(e);
		end
	endtask

	task automatic load_weights();
		for (int t = 0; t < NUM_TAPS && !aborted; t++) begin
			for (int c = 0; c < NUM_CH; c++) begin
				@(posedge clk);
				wgt_we <= 1'b1;
				wgt_wr <= '{tap: TAP_W'(t), ch: CH_W'(c), value: WGT_W'(wgt_m[t][c])};
			end
		end
		@(posedge clk);
		wgt_we <= 1'b0;
	endtask

	task automatic drive_beats(input bit gaps);
		int idx;
		int waited;
		idx = 0;
		waited = 0;
		while (!aborted && idx < stim_q.size()) begin
			@(posedge clk);
			if (in_valid && in_ready) begin
				idx++;
				waited = 0;
			end else begin
				waited++;
			end
			if (waited > WAIT_LIMIT) begin
				$display("%s: input beat %0d was never accepted", cur_test, idx);
				other_errs++;
				aborted = 1'b1;
				in_valid <= 1'b0;
			end else if (!(in_valid && !in_ready)) begin		// a refused beat stays on offer
				if (idx < stim_q.size() && (!gaps || $urandom_range(0, 3) != 0)) begin
					in_valid <= 1'b1;
					in_data  <= stim_q[idx];
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		stim_q.delete();
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (!aborted && exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("%s: %0d expected outputs never appeared", cur_test, exp_q.size());
				other_errs++;
				aborted = 1'b1;
			end
		end
		repeat (5) @(posedge clk);		// room for a stray extra output to show
	endtask

	task automatic check_count(input int base, input int n);
		if (out_count - base != n) begin
			$display("[FAIL] %s: expected %0d outputs, actual %0d", cur_test, n, out_count - base);
			value_errs++;
		end
	endtask

	task automatic test_reset();
		cur_test = "test_reset";
		repeat (8) begin
			@(posedge clk);
			if (out_valid !== 1'b0) begin
				$display("[FAIL] %s: out_valid expected 0, actual %b", cur_test, out_valid);
				value_errs++;
			end
		end
		rst_n <= 1'b1;
		repeat (10) begin
			@(posedge clk);
			if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
				$display("[FAIL] %s: out_valid/in_ready expected 0/1, actual %b/%b",
					cur_test, out_valid, in_ready);
				value_errs++;
			end
		end
	endtask

	task automatic test_single_frame();
		int base;
		cur_test = "test_single_frame";
		base = out_count;
		for (int t = 0; t < NUM_TAPS; t++)
			for (int c = 0; c < NUM_CH; c++) wgt_m[t][c] = ((t * 5 + c * 3) % 9) - 3;
		load_weights();
		fill_acts(1'b0);
		queue_frame();
		drive_beats(1'b0);
		wait_drain();
		check_count(base, ROW_BEATS);
	endtask

	// tap 0 gives T = 64*a0 + a1 - 128*a2 so each lane can hit an exact total
	task automatic test_thresholds();
		int targets [15];
		int tgt;
		int neg;
		int rest;
		cur_test = "test_thresholds";
		targets = '{(Q_REF0 << QSHIFT) - 1, Q_REF0 << QSHIFT, (Q_REF1 << QSHIFT) - 1,
			Q_REF1 << QSHIFT, (Q_REF2 << QSHIFT) - 1, Q_REF2 << QSHIFT,
			(Q_REF0 - 1) << QSHIFT, (Q_REF2 << QSHIFT) + 127, 0, -1, -128, -129,
			-(Q_REF2 << QSHIFT), 127, 128};
		for (int t = 0; t < NUM_TAPS; t++)
			for (int c = 0; c < NUM_CH; c++) wgt_m[t][c] = 0;
		wgt_m[0][0] = 64;
		wgt_m[0][1] = 1;
		wgt_m[0][2] = -128;
		load_weights();
		fill_acts(1'b1);
		for (int i = 0; i < ROW_BEATS * NUM_LANES; i++) begin
			tgt = (i < 15) ? targets[i] : int'($urandom_range(0, 20000)) - 4000;
			neg = (tgt < 0) ? (127 - tgt) / 128 : 0;
			rest = tgt + neg * 128;
			frame_act[0][i / NUM_LANES].px[i % NUM_LANES][0] = 8'(rest / 64);
			frame_act[0][i / NUM_LANES].px[i % NUM_LANES][1] = 8'(rest % 64);
			frame_act[0][i / NUM_LANES].px[i % NUM_LANES][2] = 8'(neg);
		end
		queue_frame();
		drive_beats(1'b0);
		wait_drain();
	endtask

	task automatic test_backpressure();
		int base;
		cur_test = "test_backpressure";
		base = out_count;
		for (int t = 0; t < NUM_TAPS; t++)
			for (int c = 0; c < NUM_CH; c++) wgt_m[t][c] = int'($urandom_range(0, 255)) - 128;
		load_weights();
		fill_acts(1'b1);
		queue_frame();
		bp_mode = 1'b1;
		drive_beats(1'b1);
		wait_drain();
		bp_mode = 1'b0;
		check_count(base, ROW_BEATS);
	endtask

	// same activations twice with only the weights changing between the frames
	task automatic test_weight_reload();
		int base;
		cur_test = "test_weight_reload";
		base = out_count;
		for (int t = 0; t < NUM_TAPS; t++)
			for (int c = 0; c < NUM_CH; c++) wgt_m[t][c] = 2 - ((t + c) % 5);
		load_weights();
		fill_acts(1'b1);
		queue_frame();
		drive_beats(1'b0);
		wait_drain();
		for (int t = 0; t < NUM_TAPS; t++)
			for (int c = 0; c < NUM_CH; c++) wgt_m[t][c] = int'($urandom_range(0, 63)) - 16;
		load_weights();
		queue_frame();
		drive_beats(1'b0);
		wait_drain();
		check_count(base, 2 * ROW_BEATS);
	endtask

	task automatic test_back_to_back();
		int base;
		cur_test = "test_back_to_back";
		base = out_count;
		for (int f = 0; f < 3; f++) begin
			fill_acts(1'b1);
			queue_frame();
		end
		drive_beats(1'b0);
		wait_drain();
		check_count(base, 3 * ROW_BEATS);
	endtask

	initial begin
		void'($urandom(32'hfa94b0a8));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		wgt_we   = 1'b0;
		wgt_wr   = '0;
		test_reset();
		test_single_frame();
		test_thresholds();
		test_backpressure();
		test_weight_reload();
		test_back_to_back();
		finish_run();
	end

endmodule

// File: compile.f
hw/conv0_pkg.sv
hw/psum_fifo.sv
hw/conv0_seq.sv
hw/conv0_mac.sv
hw/conv0_go.sv
hw/conv0_top.sv
tb/conv0_tb.sv

// File: run.sh
#!/bin/sh
# build the conv0 testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module conv0_tb -f compile.f \
	-Mdir obj_dir -o conv0_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/conv0_sim > sim.log 2>&1 || echo "simulation exited with an error status"
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "failure found in sim.log"; exit 1; } \
	|| echo "no failure found in sim.log"
grep -q "RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
